/* verilog/vecmul_pkg.sv */
// Element format and shared constants for the vector multiplier

package vecmul_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Field widths
  ///////////////////////////////////////////////////////////////////////

  // Two's-complement exponent
  localparam int EXP_W = 8;

  // Unsigned integer mantissa, no hidden bit
  localparam int MANT_W = 23;

  // Sign plus exponent plus mantissa
  localparam int WORD_W = 1 + EXP_W + MANT_W;

  // Issue edge to done pulse
  // One latch cycle, MANT_W shift-add steps, one normalize cycle
  localparam int MUL_LATENCY = MANT_W + 2;

  ///////////////////////////////////////////////////////////////////////
  // Element word
  ///////////////////////////////////////////////////////////////////////

  // Decoded view, sign in the top bit
  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [MANT_W-1:0] mant;
  } elem_fields_t;

  // Same word, raw at the ports and split in the multiplier
  typedef union packed {
    logic [WORD_W-1:0] raw;
    elem_fields_t      f;
  } elem_t;

endpackage

/* verilog/operand_if.sv */
// Operand pair link from the capture stage to the scalar multiplier

`timescale 1ns/1ns

interface operand_if;
  import vecmul_pkg::*;

  // One-cycle request, only while busy is low
  logic  issue;

  // Operand pair, stable while issue is high
  elem_t a;
  elem_t b;

  // Pair is the final element of the vector
  logic  last;

  // Multiplier level, high from the cycle after issue through done
  logic  busy;

  // Capture side
  modport source (output issue, output a, output b, output last, input busy);

  // Multiplier side
  modport sink (input issue, input a, input b, input last, output busy);

endinterface

/* verilog/operand_capture.sv */
// Input side, samples the length, pairs A and B operands, tags the last element

`timescale 1ns/1ns

module operand_capture #(
  parameter int SIZE_W = 16
) (
  input  logic               CLK,
  input  logic               RST,
  input  logic               start,
  input  logic [SIZE_W-1:0]  size,
  input  logic               a_enable,
  input  vecmul_pkg::elem_t  a_data,
  input  logic               b_enable,
  input  vecmul_pkg::elem_t  b_data,
  operand_if.source          op
);
  import vecmul_pkg::*;

  ///////////////////////////////////////////////////////////////////////
  // Signals
  ///////////////////////////////////////////////////////////////////////

  // Idle when low
  logic              active;

  // Sampled vector length and issued elements
  logic [SIZE_W-1:0] len;
  logic [SIZE_W-1:0] count;

  // Operand slots
  elem_t             slot_a;
  elem_t             slot_b;
  logic              a_full;
  logic              b_full;

  // Registered link outputs
  logic              issue_q;
  logic              last_q;

  logic              a_take;
  logic              b_take;
  logic              fire;
  logic              at_last;

  ///////////////////////////////////////////////////////////////////////
  // Control
  ///////////////////////////////////////////////////////////////////////

  // Slot write, operands seen only while a vector runs
  assign a_take = active && a_enable && !a_full;
  assign b_take = active && b_enable && !b_full;

  // Pair complete and multiplier free
  // issue_q guards the cycle before busy rises
  assign fire = active && a_full && b_full && !op.busy && !issue_q;

  assign at_last = (count == len - SIZE_W'(1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active  <= 1'b0;
      len     <= '0;
      count   <= '0;
      a_full  <= 1'b0;
      b_full  <= 1'b0;
      issue_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      issue_q <= 1'b0;
      if (!active) begin
        // START ignored while a vector is running
        if (start) begin
          active <= 1'b1;
          len    <= size;
          count  <= '0;
        end
      end else begin
        if (a_take) a_full <= 1'b1;
        if (b_take) b_full <= 1'b1;
        if (fire) begin
          issue_q <= 1'b1;
          last_q  <= at_last;
          a_full  <= 1'b0;
          b_full  <= 1'b0;
          count   <= count + SIZE_W'(1);
          // Back to idle once the final pair is out
          if (at_last) active <= 1'b0;
        end
      end
    end
  end

  // Operand payload
  always_ff @(posedge CLK) begin
    if (a_take) slot_a <= a_data;
    if (b_take) slot_b <= b_data;
  end

  assign op.issue = issue_q;
  assign op.a     = slot_a;
  assign op.b     = slot_b;
  assign op.last  = last_q;

  ///////////////////////////////////////////////////////////////////////
  // Checks
  ///////////////////////////////////////////////////////////////////////

  // Source must wait for the slots to drain
  assert property (@(posedge CLK) disable iff (RST)
    !((a_enable && a_full) || (b_enable && b_full)))
    else $error("operand dropped at a full slot");

  // Zero-length vectors are not supported
  assert property (@(posedge CLK) disable iff (RST)
    (start && !active) |-> (size != '0))
    else $error("START accepted with zero SIZE_IN");

endmodule

/* verilog/scalar_multiplier.sv */
// Processing part, sequential shift-add multiplier with exponent add and normalization

`timescale 1ns/1ns

module scalar_multiplier (
  input  logic               CLK,
  input  logic               RST,
  operand_if.sink            op,
  output logic               done,
  output vecmul_pkg::elem_t  product,
  output logic               last_out
);
  import vecmul_pkg::*;

  ///////////////////////////////////////////////////////////////////////
  // Constants
  ///////////////////////////////////////////////////////////////////////

  // Full-width mantissa product
  localparam int PROD_W = 2 * MANT_W;

  // Leading one position, 0 for a zero product
  localparam int LEAD_W = $clog2(PROD_W + 1);

  // Step counter, counts 0 to MANT_W
  localparam int STEP_W = $clog2(MANT_W + 1);

  ///////////////////////////////////////////////////////////////////////
  // Signals
  ///////////////////////////////////////////////////////////////////////

  logic              busy_q;
  logic              running;
  logic [STEP_W-1:0] step;

  // Latched on issue
  logic              sign_q;
  logic [EXP_W-1:0]  exp_q;
  logic              last_q;

  // Shift-add datapath
  logic [PROD_W-1:0] mcand;
  logic [MANT_W-1:0] mplier;
  logic [PROD_W-1:0] acc;

  // Normalization
  logic [LEAD_W-1:0] lead;
  logic [LEAD_W-1:0] norm_shift;
  logic [MANT_W-1:0] norm_mant;
  logic [EXP_W-1:0]  norm_exp;

  logic              last_step;

  assign last_step = running && (step == STEP_W'(MANT_W));

  ///////////////////////////////////////////////////////////////////////
  // Control
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q  <= 1'b0;
      running <= 1'b0;
      step    <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (op.issue) begin
        busy_q  <= 1'b1;
        running <= 1'b1;
        step    <= '0;
      end else if (running) begin
        // Steps 0 to MANT_W-1 shift-add, step MANT_W normalizes
        if (last_step) begin
          running <= 1'b0;
          done    <= 1'b1;
        end else begin
          step <= step + STEP_W'(1);
        end
      end else if (done) begin
        // Busy held through the done cycle
        busy_q <= 1'b0;
      end
    end
  end

  assign op.busy = busy_q;

  ///////////////////////////////////////////////////////////////////////
  // Datapath
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (op.issue) begin
      sign_q <= op.a.f.sign ^ op.b.f.sign;
      // Exponents wrap modulo 256
      exp_q  <= op.a.f.exp + op.b.f.exp;
      last_q <= op.last;
      mcand  <= PROD_W'(op.a.f.mant);
      mplier <= op.b.f.mant;
      acc    <= '0;
    end else if (running && !last_step) begin
      // One multiplier bit per cycle, LSB first
      if (mplier[0]) acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
    if (last_step) begin
      product.f.sign <= sign_q;
      product.f.exp  <= norm_exp;
      product.f.mant <= norm_mant;
      last_out       <= last_q;
    end
  end

  // Leading one of the product, counted from 1
  always_comb begin
    lead = '0;
    for (int i = 0; i < PROD_W; i++) begin
      if (acc[i]) lead = LEAD_W'(i + 1);
    end
  end

  // Right shift just far enough to fit MANT_W bits, low bits truncated
  assign norm_shift = (lead > LEAD_W'(MANT_W)) ? lead - LEAD_W'(MANT_W) : '0;
  assign norm_mant  = MANT_W'(acc >> norm_shift);
  assign norm_exp   = exp_q + EXP_W'(norm_shift);

  ///////////////////////////////////////////////////////////////////////
  // Checks
  ///////////////////////////////////////////////////////////////////////

  // Capture must hold the pair until busy falls
  assert property (@(posedge CLK) disable iff (RST) op.issue |-> !busy_q)
    else $error("issue while multiplier busy");

  // Fixed latency from issue to done
  assert property (@(posedge CLK) disable iff (RST) op.issue |-> ##MUL_LATENCY done)
    else $error("done not MUL_LATENCY cycles after issue");

endmodule

/* verilog/result_stage.sv */
// Output side that registers each product and raises the output and ready strobes

`timescale 1ns/1ns

module result_stage (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          done,
  input  vecmul_pkg::elem_t             product,
  input  logic                          last_in,
  output logic [vecmul_pkg::WORD_W-1:0] data_out,
  output logic                          data_out_enable,
  output logic                          ready
);

  ///////////////////////////////////////////////////////////////////////
  // Strobes
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      // One strobe per element on the cycle after done
      data_out_enable <= done;
      // Vector finished with the tagged element
      ready           <= done && last_in;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Result word
  ///////////////////////////////////////////////////////////////////////

  // Held until the next product lands
  always_ff @(posedge CLK) begin
    if (done) data_out <= product.raw;
  end

  ///////////////////////////////////////////////////////////////////////
  // Checks
  ///////////////////////////////////////////////////////////////////////

  // READY never stands alone
  assert property (@(posedge CLK) disable iff (RST) ready |-> data_out_enable)
    else $error("READY without DATA_OUT_ENABLE");

  // Product word free of X when strobed
  assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> !$isunknown(data_out))
    else $error("unknown bits on DATA_OUT");

endmodule

/* verilog/vector_multiplier.sv */
// Top level of the element-wise vector multiplier

`timescale 1ns/1ns

module vector_multiplier #(
  parameter int SIZE_W = 16
) (
  // Global
  input  logic                          CLK,
  input  logic                          RST,

  // Control
  input  logic                          START,
  input  logic [SIZE_W-1:0]             SIZE_IN,
  output logic                          READY,

  // Operand A
  input  logic                          DATA_A_IN_ENABLE,
  input  logic [vecmul_pkg::WORD_W-1:0] DATA_A_IN,

  // Operand B
  input  logic                          DATA_B_IN_ENABLE,
  input  logic [vecmul_pkg::WORD_W-1:0] DATA_B_IN,

  // Result
  output logic                          DATA_OUT_ENABLE,
  output logic [vecmul_pkg::WORD_W-1:0] DATA_OUT
);
  import vecmul_pkg::*;

  // Multiplier to result stage
  logic  mul_done;
  elem_t mul_product;
  logic  mul_last;

  // Capture to multiplier
  operand_if op_bus ();

  operand_capture #(
    .SIZE_W(SIZE_W)
  ) u_capture (
    .CLK      (CLK),
    .RST      (RST),
    .start    (START),
    .size     (SIZE_IN),
    .a_enable (DATA_A_IN_ENABLE),
    .a_data   (elem_t'(DATA_A_IN)),
    .b_enable (DATA_B_IN_ENABLE),
    .b_data   (elem_t'(DATA_B_IN)),
    .op       (op_bus)
  );

  scalar_multiplier u_multiplier (
    .CLK      (CLK),
    .RST      (RST),
    .op       (op_bus),
    .done     (mul_done),
    .product  (mul_product),
    .last_out (mul_last)
  );

  result_stage u_result (
    .CLK             (CLK),
    .RST             (RST),
    .done            (mul_done),
    .product         (mul_product),
    .last_in         (mul_last),
    .data_out        (DATA_OUT),
    .data_out_enable (DATA_OUT_ENABLE),
    .ready           (READY)
  );

endmodule

/* bench/tb_vector_multiplier.sv */
// Testbench for the vector multiplier, table-driven with a reference model and watchdog

`timescale 1ns/1ns

module tb_vector_multiplier;
  import vecmul_pkg::*;

  localparam int SIZE_W   = 16;
  localparam int NUM_ROWS = 6;
  localparam int MAX_LEN  = 8;

  // DUT inputs
  logic              CLK = 1'b0;
  logic              RST;
  logic              START;
  logic [SIZE_W-1:0] SIZE_IN;
  logic              DATA_A_IN_ENABLE;
  logic [WORD_W-1:0] DATA_A_IN;
  logic              DATA_B_IN_ENABLE;
  logic [WORD_W-1:0] DATA_B_IN;

  // DUT outputs
  logic              DATA_OUT_ENABLE;
  logic [WORD_W-1:0] DATA_OUT;
  logic              READY;

  // Stimulus table, one vector per row
  int                row_len [NUM_ROWS];
  logic [WORD_W-1:0] row_a   [NUM_ROWS][MAX_LEN];
  logic [WORD_W-1:0] row_b   [NUM_ROWS][MAX_LEN];

  int   errors      = 0;
  int   checked     = 0;
  int   cycle       = 0;
  int   doe_count   = 0;
  int   ready_count = 0;
  int   total_elems = 0;
  logic table_ready = 1'b0;

  vector_multiplier #(
    .SIZE_W(SIZE_W)
  ) DUT (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .SIZE_IN          (SIZE_IN),
    .READY            (READY),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .DATA_B_IN        (DATA_B_IN),
    .DATA_OUT_ENABLE  (DATA_OUT_ENABLE),
    .DATA_OUT         (DATA_OUT)
  );

  always #5 CLK = ~CLK;

  // Rising edges since time zero
  always @(posedge CLK) cycle <= cycle + 1;

  // Strobe counters, sampled mid-cycle
  always @(negedge CLK) begin
    if (!RST) begin
      if (DATA_OUT_ENABLE) doe_count++;
      if (READY) ready_count++;
      if (READY && !DATA_OUT_ENABLE) begin
        errors++;
        $display("READY seen without DATA_OUT_ENABLE at %0t ns", $time);
      end
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Helpers
  ///////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Step to 1 ns past the next rising edge
  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  function automatic logic [WORD_W-1:0] pack_word(input logic sign, input int exp_val,
                                                  input int mant_val);
    logic [EXP_W-1:0]  e;
    logic [MANT_W-1:0] m;
    e = exp_val[EXP_W-1:0];
    m = mant_val[MANT_W-1:0];
    return {sign, e, m};
  endfunction

  // Expected product: sign xor, exponent sum, mantissa shifted down to MANT_W bits
  task automatic model_product(input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b,
                               output logic [WORD_W-1:0] p);
    logic [2*MANT_W-1:0] mant;
    logic [EXP_W-1:0]    e;
    int                  shift;
    mant  = {{MANT_W{1'b0}}, a[MANT_W-1:0]} * {{MANT_W{1'b0}}, b[MANT_W-1:0]};
    shift = 0;
    while ((mant >> MANT_W) != '0) begin
      mant = mant >> 1;
      shift++;
    end
    e = a[WORD_W-2 -: EXP_W] + b[WORD_W-2 -: EXP_W] + EXP_W'(shift);
    p = {a[WORD_W-1] ^ b[WORD_W-1], e, mant[MANT_W-1:0]};
  endtask

  // One-cycle strobe on the A or B port
  task automatic pulse_operand(input logic is_a, input logic [WORD_W-1:0] word);
    if (is_a) begin
      DATA_A_IN        = word;
      DATA_A_IN_ENABLE = 1'b1;
    end else begin
      DATA_B_IN        = word;
      DATA_B_IN_ENABLE = 1'b1;
    end
    next_cycle();
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
  endtask

  // Mode 0 A first, 1 B first, 2 both in one cycle
  // seen is the edge where the later strobe is sampled
  task automatic send_pair(input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b,
                           input int mode, input int gap, output int seen);
    if (mode == 2) begin
      DATA_A_IN        = a;
      DATA_B_IN        = b;
      DATA_A_IN_ENABLE = 1'b1;
      DATA_B_IN_ENABLE = 1'b1;
      seen             = cycle + 1;
      next_cycle();
      DATA_A_IN_ENABLE = 1'b0;
      DATA_B_IN_ENABLE = 1'b0;
    end else begin
      pulse_operand(mode == 0, (mode == 0) ? a : b);
      repeat (gap) next_cycle();
      seen = cycle + 1;
      pulse_operand(mode != 0, (mode == 0) ? b : a);
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Stimulus table
  ///////////////////////////////////////////////////////////////////////

  task automatic build_table();
    int e;
    foreach (row_a[r, k]) begin
      row_a[r][k] = '0;
      row_b[r][k] = '0;
    end
    // Single element, READY with the only strobe
    row_len[0] = 1;
    row_a[0][0] = pack_word(1'b0, 3, 5);
    row_b[0][0] = pack_word(1'b1, -2, 7);
    // No shift, full 23-bit shift, one-bit shift, zero mantissa
    row_len[1] = 4;
    row_a[1][0] = pack_word(1'b0, -5, 1000);
    row_b[1][0] = pack_word(1'b1, -3, 2000);
    row_a[1][1] = pack_word(1'b1, 0, 'h7FFFFF);
    row_b[1][1] = pack_word(1'b1, 0, 'h7FFFFF);
    row_a[1][2] = pack_word(1'b0, -10, 'h400000);
    row_b[1][2] = pack_word(1'b1, 4, 2);
    row_a[1][3] = pack_word(1'b1, 7, 0);
    row_b[1][3] = pack_word(1'b0, -7, 'h123456);
    // Negative exponents, mixed signs
    row_len[2] = 2;
    row_a[2][0] = pack_word(1'b1, -20, 'h3FF);
    row_b[2][0] = pack_word(1'b0, -20, 'h7FF);
    row_a[2][1] = pack_word(1'b0, 12, 'h7FFFFF);
    row_b[2][1] = pack_word(1'b1, -30, 1);
    // Random rows, exponents within +-20 so sums stay in range
    for (int r = 3; r < NUM_ROWS; r++) begin
      row_len[r] = 1 + int'($urandom % MAX_LEN);
      for (int k = 0; k < row_len[r]; k++) begin
        e = int'($urandom % 41) - 20;
        row_a[r][k] = pack_word($urandom % 2 == 1, e, int'($urandom));
        e = int'($urandom % 41) - 20;
        row_b[r][k] = pack_word($urandom % 2 == 1, e, int'($urandom));
      end
    end
    foreach (row_len[r]) total_elems += row_len[r];
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Main sequence
  ///////////////////////////////////////////////////////////////////////

  initial begin
    int                len;
    int                mode;
    int                gap;
    int                seen;
    int                elem_total;
    int                doe_base;
    int                ready_base;
    logic [WORD_W-1:0] expected;
    void'($urandom(28025));
    RST              = 1'b1;
    START            = 1'b0;
    SIZE_IN          = '0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_A_IN        = '0;
    DATA_B_IN_ENABLE = 1'b0;
    DATA_B_IN        = '0;
    elem_total       = 0;
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Quiet outputs until the first START
    repeat (20) next_cycle();
    compare_value("DATA_OUT_ENABLE count before START", 32'(doe_count), 32'd0);
    compare_value("READY count before START", 32'(ready_count), 32'd0);

    for (int row = 0; row < NUM_ROWS; row++) begin
      len        = row_len[row];
      doe_base   = doe_count;
      ready_base = ready_count;
      START      = 1'b1;
      SIZE_IN    = SIZE_W'(len);
      next_cycle();
      START      = 1'b0;
      for (int k = 0; k < len; k++) begin
        mode = elem_total % 3;
        gap  = (elem_total % 4 == 3) ? 12 : int'($urandom % 4);
        send_pair(row_a[row][k], row_b[row][k], mode, gap, seen);
        while (DATA_OUT_ENABLE !== 1'b1) next_cycle();
        model_product(row_a[row][k], row_b[row][k], expected);
        compare_value("DATA_OUT", DATA_OUT, expected);
        compare_value("READY", 32'(READY), 32'(k == len - 1));
        if (cycle - seen < MUL_LATENCY + 2) begin
          errors++;
          $display("DATA_OUT_ENABLE came only %0d cycles after the operands at %0t ns",
                   cycle - seen, $time);
        end
        checked++;
        elem_total++;
        next_cycle();
        // A second START mid-vector must be ignored
        if (k == 0 && len > 1) begin
          START   = 1'b1;
          SIZE_IN = SIZE_W'(7);
          next_cycle();
          START   = 1'b0;
        end
      end
      repeat (5) next_cycle();
      compare_value("DATA_OUT_ENABLE count", 32'(doe_count - doe_base), 32'(len));
      compare_value("READY count", 32'(ready_count - ready_base), 32'd1);
    end

    $display("Summary: %0d elements checked, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog, budget per element plus reset and idle margin
  initial begin : watchdog
    int limit_ns;
    wait (table_ready);
    limit_ns = total_elems * (MUL_LATENCY + 20) * 10 + 2000;
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("Test failures found");
    $finish;
  end

endmodule

/* sim.f */
verilog/vecmul_pkg.sv
verilog/operand_if.sv
verilog/operand_capture.sv
verilog/scalar_multiplier.sv
verilog/result_stage.sv
verilog/vector_multiplier.sv
bench/tb_vector_multiplier.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vector multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_vector_multiplier -Mdir obj_dir

out=$(./obj_dir/Vtb_vector_multiplier)
echo "$out"

if echo "$out" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1
